// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= burst_buffer_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
EXTRA     ?=

VFLAGS = --assert --timing --top-module $(TOP) -f $(FILELIST) $(EXTRA)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'No errors'

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/beat_counter.sv ====
// load and take are expected never to be high in the same cycle.
`timescale 1ns/1ps

module beat_counter
        import buf_ctrl_pkg::*;
(
        input  logic       w_clk,
        input  logic       w_reset_n,
        input  logic       load,
        input  burst_len_t load_len,
        input  logic       take,
        output burst_len_t beats_left,
        output logic       last_beat
);

        always_ff @(posedge w_clk)
        begin
                if (!w_reset_n)
                        beats_left <= '0;
                else if (load)
                        beats_left <= load_len;
                else if (take && beats_left != '0)
                        beats_left <= beats_left - burst_len_t'(1);
        end

        // The word taken now is the final one of the burst.
        assign last_beat = (beats_left == burst_len_t'(1));

endmodule

// ==== rtl/buf_ctrl_pkg.sv ====
// Burst lengths above 31 beats do not fit burst_len_t.
package buf_ctrl_pkg;

        localparam int BURST_LEN_W = 5;

        // Beats in one burst.
        typedef logic [BURST_LEN_W-1:0] burst_len_t;

        // Controller states.
        typedef enum logic [1:0] {
                IDLE  = 2'd0,
                START = 2'd1,
                MOVE  = 2'd2
        } burst_state_e;

endpackage

// ==== rtl/buf_types_pkg.sv ====
// Payload is fixed at 32 bits, and level_t only covers FIFO depths up to 16.
package buf_types_pkg;

        localparam int DATA_W  = 32;
        localparam int LEVEL_W = 5;

        // One payload word.
        typedef logic [DATA_W-1:0] data_word_t;

        // Occupancy, from zero up to the full depth.
        typedef logic [LEVEL_W-1:0] level_t;

endpackage

// ==== rtl/burst_buffer_top.sv ====
// Single clock only; writes are dropped silently while full is high.
`timescale 1ns/1ps

module burst_buffer_top
        import buf_types_pkg::*;
        import buf_ctrl_pkg::*;
#(
        parameter int FIFO_DEPTH = 8,
        parameter int BURST_LEN  = 4
)
(
        input  logic       w_clk,
        input  logic       w_reset_n,
        input  logic       wr,
        input  data_word_t wr_data,
        input  logic       flush,
        input  logic       out_ready,
        output logic       full,
        output logic       burst_start,
        output burst_len_t burst_len,
        output logic       out_valid,
        output data_word_t out_data,
        output logic       out_last
);

        data_word_t     rd_data;
        level_t         level;
        logic           empty;
        logic           rd;
        logic           take;
        logic           load;
        burst_len_t     load_len;
        burst_len_t     beats_left;
        logic           last_beat;
        logic           stage_free;

        sync_fifo_data #(
                .FIFO_DEPTH (FIFO_DEPTH)
        ) u_fifo (
                .w_clk      (w_clk),
                .w_reset_n  (w_reset_n),
                .wr         (wr),
                .wr_data    (wr_data),
                .rd         (rd),
                .rd_data    (rd_data),
                .empty      (empty),
                .full       (full),
                .level      (level)
        );

        beat_counter u_beats (
                .w_clk      (w_clk),
                .w_reset_n  (w_reset_n),
                .load       (load),
                .load_len   (load_len),
                .take       (take),
                .beats_left (beats_left),
                .last_beat  (last_beat)
        );

        out_stage u_out (
                .w_clk      (w_clk),
                .w_reset_n  (w_reset_n),
                .take       (take),
                .rd_data    (rd_data),
                .last_beat  (last_beat),
                .out_ready  (out_ready),
                .out_valid  (out_valid),
                .out_data   (out_data),
                .out_last   (out_last),
                .stage_free (stage_free)
        );

        burst_ctrl #(
                .FIFO_DEPTH (FIFO_DEPTH),
                .BURST_LEN  (BURST_LEN)
        ) u_ctrl (
                .w_clk       (w_clk),
                .w_reset_n   (w_reset_n),
                .flush       (flush),
                .level       (level),
                .empty       (empty),
                .stage_free  (stage_free),
                .beats_left  (beats_left),
                .rd          (rd),
                .take        (take),
                .load        (load),
                .load_len    (load_len),
                .burst_start (burst_start),
                .burst_len   (burst_len)
        );

endmodule

// ==== rtl/burst_ctrl.sv ====
// BURST_LEN above FIFO_DEPTH is clamped to the depth, so such a burst never waits forever.
`timescale 1ns/1ps

module burst_ctrl
        import buf_types_pkg::*;
        import buf_ctrl_pkg::*;
#(
        parameter int FIFO_DEPTH = 8,
        parameter int BURST_LEN  = 4
)
(
        input  logic       w_clk,
        input  logic       w_reset_n,
        input  logic       flush,
        input  level_t     level,
        input  logic       empty,
        input  logic       stage_free,
        input  burst_len_t beats_left,
        output logic       rd,
        output logic       take,
        output logic       load,
        output burst_len_t load_len,
        output logic       burst_start,
        output burst_len_t burst_len
);

        localparam int START_LVL = (BURST_LEN < FIFO_DEPTH) ? BURST_LEN : FIFO_DEPTH;

        burst_state_e   state;
        logic           flush_pend;
        logic           full_ready;
        logic           flush_ready;
        logic           pop;

        assign full_ready  = (level >= level_t'(START_LVL));
        assign flush_ready = flush_pend && !empty;

        // One pop feeds both the FIFO and the output register.
        assign pop  = (state == MOVE) && stage_free && !empty;
        assign rd   = pop;
        assign take = pop;

        assign burst_start = (state == START);
        assign load        = burst_start;
        assign load_len    = burst_len;

        always_ff @(posedge w_clk)
        begin
                if (!w_reset_n)
                begin
                        state     <= IDLE;
                        burst_len <= '0;
                end
                else
                begin
                        case (state)
                                IDLE:
                                begin
                                        if (full_ready)
                                        begin
                                                state     <= START;
                                                burst_len <= burst_len_t'(START_LVL);
                                        end
                                        else if (flush_ready)
                                        begin
                                                // Short remainder, take all that is stored.
                                                state     <= START;
                                                burst_len <= burst_len_t'(level);
                                        end
                                end
                                START:
                                        state <= MOVE;
                                MOVE:
                                begin
                                        if (pop && beats_left == burst_len_t'(1))
                                                state <= IDLE;
                                end
                                default:
                                        state <= IDLE;
                        endcase
                end
        end

        // A new flush wins over the clear of an older one.
        always_ff @(posedge w_clk)
        begin
                if (!w_reset_n)
                        flush_pend <= 1'b0;
                else if (flush)
                        flush_pend <= 1'b1;
                else if (state == IDLE && !full_ready && flush_ready)
                        flush_pend <= 1'b0;
        end

endmodule

// ==== rtl/out_stage.sv ====
// take must only be raised while stage_free is high, or a held word is overwritten.
`timescale 1ns/1ps

module out_stage
        import buf_types_pkg::*;
(
        input  logic       w_clk,
        input  logic       w_reset_n,
        input  logic       take,
        input  data_word_t rd_data,
        input  logic       last_beat,
        input  logic       out_ready,
        output logic       out_valid,
        output data_word_t out_data,
        output logic       out_last,
        output logic       stage_free
);

        // Empty now, or emptied by the consumer at this edge.
        assign stage_free = !out_valid || out_ready;

        always_ff @(posedge w_clk)
        begin
                if (!w_reset_n)
                begin
                        out_valid <= 1'b0;
                        out_last  <= 1'b0;
                end
                else if (take)
                begin
                        out_valid <= 1'b1;
                        out_last  <= last_beat;
                end
                else if (out_ready)
                begin
                        out_valid <= 1'b0;
                        out_last  <= 1'b0;
                end
        end

        always_ff @(posedge w_clk)
        begin
                if (take)
                        out_data <= rd_data;
        end

endmodule

// ==== rtl/sync_fifo_data.sv ====
// FIFO_DEPTH must be a power of two from 4 to 16; flags may lag the pointers by one cycle.
`timescale 1ns/1ps

module sync_fifo_data
        import buf_types_pkg::*;
#(
        parameter int FIFO_DEPTH = 8
)
(
        input  logic       w_clk,
        input  logic       w_reset_n,
        input  logic       wr,
        input  data_word_t wr_data,
        input  logic       rd,
        output data_word_t rd_data,
        output logic       empty,
        output logic       full,
        output level_t     level
);

        localparam int AW = $clog2(FIFO_DEPTH);

        data_word_t     mem [FIFO_DEPTH];
        logic [AW:0]    wr_ptr;
        logic [AW:0]    rd_ptr;
        logic [AW:0]    next_wr_ptr;
        logic [AW:0]    next_rd_ptr;
        logic [AW:0]    ptr_diff;
        logic           do_wr;
        logic           do_rd;

        // Refused strobes leave the pointers alone.
        assign do_wr = wr && !full;
        assign do_rd = rd && !empty;

        assign next_wr_ptr = do_wr ? wr_ptr + (AW+1)'(1) : wr_ptr;
        assign next_rd_ptr = do_rd ? rd_ptr + (AW+1)'(1) : rd_ptr;

        always_ff @(posedge w_clk)
        begin
                if (do_wr)
                        mem[wr_ptr[AW-1:0]] <= wr_data;
        end

        always_ff @(posedge w_clk)
        begin
                if (!w_reset_n)
                begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end
                else
                begin
                        wr_ptr <= next_wr_ptr;
                        rd_ptr <= next_rd_ptr;
                end
        end

        // Both flags err on the safe side for one cycle.
        always_ff @(posedge w_clk)
        begin
                if (!w_reset_n)
                begin
                        empty <= 1'b1;
                        full  <= 1'b0;
                end
                else
                begin
                        empty <= (next_rd_ptr == wr_ptr);
                        full  <= (next_wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) &&
                                 (next_wr_ptr[AW] != rd_ptr[AW]);
                end
        end

        // Extra pointer bit makes the difference exact at full depth.
        assign ptr_diff = wr_ptr - rd_ptr;
        assign level    = level_t'(ptr_diff);

        assign rd_data = mem[rd_ptr[AW-1:0]];

endmodule

// ==== sim/burst_buffer_props.sv ====
// Bound into burst_buffer_top; every check is held off while w_reset_n is low.
`timescale 1ns/1ps

module burst_buffer_props
        import buf_types_pkg::*;
(
        input logic       w_clk,
        input logic       w_reset_n,
        input logic       burst_start,
        input logic       rd,
        input logic       empty,
        input logic       full,
        input logic       out_ready,
        input logic       out_valid,
        input data_word_t out_data
);

        start_pulse: assert property (
                @(posedge w_clk) disable iff (!w_reset_n) burst_start |=> !burst_start
        ) else $error("burst_start was high for two cycles in a row");

        no_pop_empty: assert property (
                @(posedge w_clk) disable iff (!w_reset_n) !(rd && empty)
        ) else $error("FIFO popped while empty");

        flags_apart: assert property (
                @(posedge w_clk) disable iff (!w_reset_n) !(full && empty)
        ) else $error("full and empty both high");

        // A stalled word stays put.
        stall_hold: assert property (
                @(posedge w_clk) disable iff (!w_reset_n)
                out_valid && !out_ready |=> out_valid && $stable(out_data)
        ) else $error("output word changed while out_ready was low");

endmodule

bind burst_buffer_top burst_buffer_props u_props (
        .w_clk       (w_clk),
        .w_reset_n   (w_reset_n),
        .burst_start (burst_start),
        .rd          (rd),
        .empty       (empty),
        .full        (full),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_data    (out_data)
);

// ==== sim/burst_buffer_tb.sv ====
// Default parameters only; the fixed seed makes every run replay the same stimulus.
`timescale 1ns/1ps

module burst_buffer_tb
        import buf_types_pkg::*;
        import buf_ctrl_pkg::*;
();

        localparam int FIFO_DEPTH = 8;
        localparam int BURST_LEN  = 4;

        logic           w_clk;
        logic           w_reset_n;
        logic           wr;
        data_word_t     wr_data;
        logic           flush;
        logic           out_ready;
        logic           full;
        logic           burst_start;
        burst_len_t     burst_len;
        logic           out_valid;
        data_word_t     out_data;
        logic           out_last;

        // Words accepted but not yet delivered, and lengths of bursts still open.
        data_word_t     model_q[$];
        int unsigned    len_q[$];
        int unsigned    beat_cnt;
        logic           pend;
        logic           flush_prev;
        logic           wr_last;

        burst_buffer_top #(
                .FIFO_DEPTH (FIFO_DEPTH),
                .BURST_LEN  (BURST_LEN)
        ) UUT (
                .w_clk       (w_clk),
                .w_reset_n   (w_reset_n),
                .wr          (wr),
                .wr_data     (wr_data),
                .flush       (flush),
                .out_ready   (out_ready),
                .full        (full),
                .burst_start (burst_start),
                .burst_len   (burst_len),
                .out_valid   (out_valid),
                .out_data    (out_data),
                .out_last    (out_last)
        );

        initial
        begin
                w_clk = 1'b0;
        end

        always #4 w_clk = ~w_clk;

        task automatic abort_run(input string msg);
        begin
                $display("%s", msg);
                $display("Errors found");
                $fatal(1, "Simulation stopped at the first error.");
        end
        endtask

        // Checks the edge just passed, drives new inputs, predicts the coming edge.
        task automatic cycle(input logic n_wr, input data_word_t n_data,
                             input logic n_flush, input logic n_ready);
                data_word_t head;
                logic       short_burst;
                int         open_beats;
                int         free_words;
        begin
                @(negedge w_clk);
                short_burst = 1'b0;
                if (burst_start)
                begin
                        // Stored words not yet claimed by an earlier burst.
                        open_beats = 0;
                        foreach (len_q[j])
                                open_beats += int'(len_q[j]);
                        free_words = model_q.size() - open_beats + int'(beat_cnt);
                        if (wr_last)
                                free_words--;
                        short_burst = free_words < BURST_LEN;
                        if (short_burst)
                        begin
                                assert (pend && free_words != 0)
                                else abort_run($sformatf(
                                        "Fail %0t: burst of %0d with %0d words and no flush",
                                        $time, burst_len, free_words));
                                assert (int'(burst_len) == free_words)
                                else abort_run($sformatf(
                                        "Fail %0t: flush burst of %0d, expected %0d",
                                        $time, burst_len, free_words));
                        end
                        else
                        begin
                                assert (burst_len == burst_len_t'(BURST_LEN))
                                else abort_run($sformatf("Fail %0t: burst of %0d, expected %0d",
                                        $time, burst_len, BURST_LEN));
                        end
                        len_q.push_back(32'(burst_len));
                end
                // A new flush wins over the clear.
                if (flush_prev)
                        pend = 1'b1;
                else if (short_burst)
                        pend = 1'b0;

                wr         = n_wr;
                wr_data    = n_data;
                flush      = n_flush;
                out_ready  = n_ready;
                flush_prev = n_flush;

                if (out_valid && n_ready)
                begin
                        assert (model_q.size() != 0 && len_q.size() != 0)
                        else abort_run($sformatf("Fail %0t: unexpected word %h",
                                $time, out_data));
                        head = model_q.pop_front();
                        beat_cnt++;
                        assert (out_data == head)
                        else abort_run($sformatf("Fail %0t: got %h, expected %h",
                                $time, out_data, head));
                        assert (out_last == (beat_cnt == len_q[0]))
                        else abort_run($sformatf("Fail %0t: out_last %0b on beat %0d of %0d",
                                $time, out_last, beat_cnt, len_q[0]));
                        if (beat_cnt == len_q[0])
                        begin
                                void'(len_q.pop_front());
                                beat_cnt = 0;
                        end
                end
                wr_last = n_wr && !full;
                if (wr_last)
                        model_q.push_back(n_data);
        end
        endtask

        // Flush only a remainder that would otherwise stay behind.
        task automatic drain_all();
                int unsigned spins;
                logic        kick;
        begin
                spins = 0;
                while (model_q.size() != 0 || len_q.size() != 0)
                begin
                        kick = model_q.size() != 0 && model_q.size() < BURST_LEN &&
                               len_q.size() == 0 && !pend && !flush_prev;
                        cycle(1'b0, '0, kick, 1'b1);
                        spins++;
                        if (spins > 200)
                                abort_run("Timeout while waiting for the buffer to drain.");
                end
        end
        endtask

        task automatic idle_no_burst(input int unsigned cycles);
        begin
                repeat (cycles)
                begin
                        cycle(1'b0, '0, 1'b0, 1'b1);
                        assert (!burst_start)
                        else abort_run($sformatf("Fail %0t: burst started with no data due",
                                $time));
                end
        end
        endtask

        initial
        begin
                int unsigned i;
                int unsigned n;
                int unsigned spins;
                int          held;
                logic        rnd_wr;
                logic        rnd_flush;
                logic        rnd_ready;

                void'($urandom(94321));
                w_reset_n  = 1'b0;
                wr         = 1'b0;
                wr_data    = '0;
                flush      = 1'b0;
                out_ready  = 1'b0;
                beat_cnt   = 0;
                pend       = 1'b0;
                flush_prev = 1'b0;
                wr_last    = 1'b0;
                repeat (2) @(negedge w_clk);
                w_reset_n = 1'b1;

                assert (!out_valid && !burst_start && !full)
                else abort_run($sformatf("Fail %0t: outputs not cleared by reset", $time));
                idle_no_burst(6);

                // Short remainder, drained by one flush pulse.
                n = 1 + ($urandom % (BURST_LEN - 1));
                for (i = 0; i < n; i++)
                        cycle(1'b1, $urandom, 1'b0, 1'b1);
                idle_no_burst(3);
                cycle(1'b0, '0, 1'b1, 1'b1);
                spins = 0;
                while (!burst_start)
                begin
                        cycle(1'b0, '0, 1'b0, 1'b1);
                        spins++;
                        if (spins > 20)
                                abort_run("Timeout waiting for the flush burst to start.");
                end
                assert (burst_len == burst_len_t'(n))
                else abort_run($sformatf("Fail %0t: flush burst of %0d, expected %0d",
                        $time, burst_len, n));
                drain_all();
                idle_no_burst(8);

                // Stalled consumer until the FIFO fills.
                spins = 0;
                while (!full)
                begin
                        cycle(1'b1, $urandom, 1'b0, 1'b0);
                        spins++;
                        if (spins > 40)
                                abort_run("Timeout waiting for full to rise.");
                end
                held = model_q.size();
                assert (held == FIFO_DEPTH + 1)
                else abort_run($sformatf("Fail %0t: %0d words held at full", $time, held));
                repeat (4)
                begin
                        cycle(1'b1, $urandom, 1'b0, 1'b0);
                        assert (full && model_q.size() == held)
                        else abort_run($sformatf("Fail %0t: full dropped while stalled",
                                $time));
                end
                drain_all();

                for (i = 0; i < 4000; i++)
                begin
                        rnd_wr    = ($urandom % 3) != 0;
                        rnd_flush = ($urandom % 50) == 0;
                        rnd_ready = ($urandom % 4) != 0;
                        cycle(rnd_wr, $urandom, rnd_flush, rnd_ready);
                end
                drain_all();

                $display("No errors");
                $finish;
        end

endmodule

// ==== verilog.f ====
rtl/buf_types_pkg.sv
rtl/buf_ctrl_pkg.sv
rtl/sync_fifo_data.sv
rtl/beat_counter.sv
rtl/out_stage.sv
rtl/burst_ctrl.sv
rtl/burst_buffer_top.sv
sim/burst_buffer_props.sv
sim/burst_buffer_tb.sv
